// ==== rtl/arm_pkg.sv ====
`default_nettype none

package arm_pkg;

    localparam int word_w     = 32;
    localparam int reg_addr_w = 4;

    typedef logic [word_w-1:0]     word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // command field of a data-processing instruction, bits 24:21
    typedef enum logic [3:0] {
        op_and = 4'b0000,
        op_sub = 4'b0010,
        op_add = 4'b0100,
        op_orr = 4'b1100,
        op_mov = 4'b1101
    } alu_op_e;

    // instruction class, bits 27:26
    typedef enum logic [1:0] {
        class_data = 2'b00,
        class_mem  = 2'b01
    } instr_class_e;

    // one instruction after decode
    typedef struct packed {
        alu_op_e   alu_op;
        logic      reg_write;
        logic      mem_write;
        logic      use_imm;
        reg_addr_t rn;
        reg_addr_t rm;
        reg_addr_t rd;
        word_t     imm;
    } decoded_op_t;

    // result on its way back to the register file
    typedef struct packed {
        logic      reg_write;
        reg_addr_t wa;
        word_t     result;
    } wb_t;

    typedef struct packed {
        logic  we;
        word_t addr;
        word_t wdata;
    } mem_port_t;

endpackage

`default_nettype wire

// ==== rtl/fetch_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_stage
    import arm_pkg::*;
#(
    parameter word_t RESET_PC = '0
) (
    input  logic  clk,
    input  logic  reset,
    input  word_t instr,
    output word_t pc,
    output word_t instr_d
);

    // no branches, so the pc only ever steps forward
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc + word_t'(4);
        end
    end

    // fetch to decode register
    // the zero word after reset decodes as a bubble
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            instr_d <= '0;
        end else begin
            instr_d <= instr;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/decode_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module decode_unit
    import arm_pkg::*;
(
    input  word_t       instr_d,
    output reg_addr_t   rn,
    output reg_addr_t   rm,
    output decoded_op_t op
);

    instr_class_e cls;
    logic         imm_bit;
    logic [3:0]   cmd;
    logic         load;
    logic         is_store;
    logic         bubble;

    ////////////////////////////////////////
    // instruction fields

    assign cls      = instr_class_e'(instr_d[27:26]);
    assign imm_bit  = instr_d[25];
    assign cmd      = instr_d[24:21];
    assign load     = instr_d[20];
    assign is_store = (cls == class_mem) && !load;
    assign bubble   = (instr_d == '0);

    assign rn = instr_d[19:16];
    // STR reads its data register on the second port
    assign rm = is_store ? instr_d[15:12] : instr_d[3:0];

    ////////////////////////////////////////
    // control and immediate

    always_comb begin
        op        = '0;
        op.alu_op = op_and;
        op.rn     = rn;
        op.rm     = rm;
        op.rd     = instr_d[15:12];
        if (cls == class_data) begin
            op.use_imm = imm_bit;
            op.imm     = {24'b0, instr_d[7:0]};
            case (cmd)
                op_and, op_sub, op_add, op_orr, op_mov: begin
                    op.alu_op    = alu_op_e'(cmd);
                    // reset bubble is AND r0,r0,r0 and must not write
                    op.reg_write = !bubble;
                end
                // unknown command falls through as a no-write
                default: ;
            endcase
        end else if (is_store) begin
            // address is base plus positive offset
            op.alu_op    = op_add;
            op.use_imm   = 1'b1;
            op.mem_write = 1'b1;
            op.imm       = {20'b0, instr_d[11:0]};
        end
    end

    // loads have no read path in this core
    always_comb begin
        if (!$isunknown(instr_d)) begin
            assert (!(cls == class_mem && load))
                else $error("load instruction %h reached decode", instr_d);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module reg_file
    import arm_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rn,
    input  reg_addr_t rm,
    input  wb_t       wb,
    output word_t     rd1,
    output word_t     rd2
);

    localparam int num_regs = 2 ** reg_addr_w;

    word_t regs [num_regs];

    // r15 is a plain register here
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.reg_write) begin
            regs[wb.wa] <= wb.result;
        end
    end

    ////////////////////////////////////////
    // read ports
    // a write in this cycle shows up at once, which covers
    // the producer three slots ahead that forwarding misses

    assign rd1 = (wb.reg_write && wb.wa == rn) ? wb.result : regs[rn];
    assign rd2 = (wb.reg_write && wb.wa == rm) ? wb.result : regs[rm];

endmodule

`default_nettype wire

// ==== rtl/alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu
    import arm_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  alu_op_e op,
    input  word_t   a,
    input  word_t   b,
    output word_t   y
);

    always_comb begin
        case (op)
            op_and:  y = a & b;
            op_sub:  y = a - b;
            op_add:  y = a + b;
            op_orr:  y = a | b;
            // mov ignores the first operand
            op_mov:  y = b;
            default: y = '0;
        endcase
    end

    // decode maps every unknown command onto op_and,
    // so nothing else may arrive through the execute register
    op_legal: assert property (
        @(posedge clk) disable iff (reset)
        op inside {op_and, op_sub, op_add, op_orr, op_mov}
    ) else $error("alu opcode %b outside the supported set", op);

endmodule

`default_nettype wire

// ==== rtl/execute_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module execute_stage
    import arm_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  decoded_op_t op,
    input  word_t       rd1,
    input  word_t       rd2,
    output mem_port_t   dmem,
    output wb_t         wb
);

    // execute stage
    decoded_op_t op_e;
    word_t       rd1_e;
    word_t       rd2_e;

    word_t src_a;
    word_t src_b;
    word_t alu_b;
    word_t alu_y;

    // memory stage
    wb_t   wb_m;
    logic  we_m;
    word_t wdata_m;

    // memory item first, then writeback item, then the latched read
    function automatic word_t forward(
        input reg_addr_t src,
        input word_t     latched,
        input wb_t       mem_item,
        input wb_t       wb_item
    );
        if (mem_item.reg_write && mem_item.wa == src) begin
            return mem_item.result;
        end else if (wb_item.reg_write && wb_item.wa == src) begin
            return wb_item.result;
        end
        return latched;
    endfunction

    ////////////////////////////////////////
    // decode to execute

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            op_e  <= '0;
            rd1_e <= '0;
            rd2_e <= '0;
        end else begin
            op_e  <= op;
            rd1_e <= rd1;
            rd2_e <= rd2;
        end
    end

    assign src_a = forward(op_e.rn, rd1_e, wb_m, wb);
    // for STR this is the store data
    assign src_b = forward(op_e.rm, rd2_e, wb_m, wb);
    assign alu_b = op_e.use_imm ? op_e.imm : src_b;

    alu alu_inst (
        .clk   (clk),
        .reset (reset),
        .op    (op_e.alu_op),
        .a     (src_a),
        .b     (alu_b),
        .y     (alu_y)
    );

    ////////////////////////////////////////
    // execute to memory

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_m    <= '0;
            we_m    <= 1'b0;
            wdata_m <= '0;
        end else begin
            wb_m.reg_write <= op_e.reg_write;
            wb_m.wa        <= op_e.rd;
            wb_m.result    <= alu_y;
            we_m           <= op_e.mem_write;
            wdata_m        <= src_b;
        end
    end

    assign dmem.we    = we_m;
    assign dmem.addr  = wb_m.result;
    assign dmem.wdata = wdata_m;

    // memory to writeback
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb <= '0;
        end else begin
            wb <= wb_m;
        end
    end

    dmem_we_known: assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown(dmem.we)
    ) else $error("data memory write enable is unknown");

endmodule

`default_nettype wire

// ==== rtl/core_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module core_top
    import arm_pkg::*;
#(
    parameter word_t RESET_PC = '0
) (
    input  logic      clk,
    input  logic      reset,
    input  word_t     instr,
    output word_t     pc,
    output mem_port_t dmem
);

    word_t       instr_d;
    reg_addr_t   rn;
    reg_addr_t   rm;
    decoded_op_t op;
    word_t       rd1;
    word_t       rd2;
    wb_t         wb;

    ////////////////////////////////////////
    // front end

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) fetch_inst (
        .clk     (clk),
        .reset   (reset),
        .instr   (instr),
        .pc      (pc),
        .instr_d (instr_d)
    );

    decode_unit decode_inst (
        .instr_d (instr_d),
        .rn      (rn),
        .rm      (rm),
        .op      (op)
    );

    reg_file reg_file_inst (
        .clk   (clk),
        .reset (reset),
        .rn    (rn),
        .rm    (rm),
        .wb    (wb),
        .rd1   (rd1),
        .rd2   (rd2)
    );

    ////////////////////////////////////////
    // back end

    execute_stage execute_inst (
        .clk   (clk),
        .reset (reset),
        .op    (op),
        .rd1   (rd1),
        .rd2   (rd2),
        .dmem  (dmem),
        .wb    (wb)
    );

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
    parameter int half_period  = 2,
    parameter int reset_cycles = 3
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // release just after an edge, like every other input
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== test/core_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module core_tb
    import arm_pkg::*;
();

    localparam word_t reset_pc = 32'h0000_0000;
    localparam int    max_rows = 64;

    // command field and condition of the instruction encoding
    localparam logic [3:0] cmd_and = 4'b0000;
    localparam logic [3:0] cmd_sub = 4'b0010;
    localparam logic [3:0] cmd_add = 4'b0100;
    localparam logic [3:0] cmd_orr = 4'b1100;
    localparam logic [3:0] cmd_mov = 4'b1101;
    localparam logic [3:0] cond_al = 4'b1110;

    logic      clk;
    logic      reset;
    word_t     instr;
    word_t     pc;
    word_t     pc_offset;
    mem_port_t dmem;

    // program and expectation table
    word_t row_word [max_rows];
    string row_name [max_rows];
    word_t row_addr [max_rows];
    word_t row_data [max_rows];
    int    n_rows;
    int    store_rows [$];

    word_t      imem [128];
    integer     seed = 11475;
    word_t      rand_word;
    logic [7:0] rand_imm;
    int         stores_seen;
    int         cycle_count;
    int         timeout_limit;
    int         row;

    tb_clock clock_inst (
        .clk   (clk),
        .reset (reset)
    );

    core_top #(
        .RESET_PC (reset_pc)
    ) core_top_inst (
        .clk   (clk),
        .reset (reset),
        .instr (instr),
        .pc    (pc),
        .dmem  (dmem)
    );

    // instruction memory answers pc in the same cycle
    assign pc_offset = pc - reset_pc;
    assign instr     = imem[pc_offset[8:2]];

    ////////////////////////////////////////
    // encoding and table helpers

    function automatic word_t imm_op(input logic [3:0] cmd, input logic [3:0] rn,
                                     input logic [3:0] rd, input logic [7:0] imm8);
        return {cond_al, 2'b00, 1'b1, cmd, 1'b0, rn, rd, 4'b0000, imm8};
    endfunction

    // shift field left at zero
    function automatic word_t reg_op(input logic [3:0] cmd, input logic [3:0] rn,
                                     input logic [3:0] rd, input logic [3:0] rm);
        return {cond_al, 2'b00, 1'b0, cmd, 1'b0, rn, rd, 8'b0, rm};
    endfunction

    // pre-indexed, offset added, word, no writeback
    function automatic word_t store_op(input logic [3:0] rn, input logic [3:0] rd,
                                       input logic [11:0] off12);
        return {cond_al, 2'b01, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, rn, rd, off12};
    endfunction

    task automatic add_op(input word_t word, input string name);
        row_word[n_rows] = word;
        row_name[n_rows] = name;
        row_addr[n_rows] = '0;
        row_data[n_rows] = '0;
        n_rows++;
    endtask

    task automatic add_store(input word_t word, input string name,
                             input word_t addr, input word_t data);
        store_rows.push_back(n_rows);
        add_op(word, name);
        row_addr[n_rows-1] = addr;
        row_data[n_rows-1] = data;
    endtask

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_equal(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("error: %s expected %h actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    ////////////////////////////////////////
    // store monitor

    always @(negedge clk) begin
        if (!reset && dmem.we) begin
            if (stores_seen >= store_rows.size()) begin
                $display("store to %h seen after the last store of the program", dmem.addr);
                abort_run();
            end else begin
                row = store_rows[stores_seen];
                check_equal($sformatf("%s address", row_name[row]), row_addr[row], dmem.addr);
                check_equal($sformatf("%s data", row_name[row]), row_data[row], dmem.wdata);
                // the store leaves memory three cycles after its fetch
                check_equal($sformatf("%s timing", row_name[row]),
                            reset_pc + word_t'(4 * (row + 3)), pc);
                stores_seen++;
            end
        end
    end

    always @(posedge clk) begin
        if (!reset) begin
            cycle_count++;
            if (cycle_count >= timeout_limit) begin
                $display("run timed out after %0d cycles", cycle_count);
                abort_run();
            end
        end
    end

    ////////////////////////////////////////
    // program and main sequence

    initial begin
        n_rows      = 0;
        stores_seen = 0;
        cycle_count = 0;
        rand_word   = $random(seed);
        rand_imm    = rand_word[7:0];

        // r0 stays zero and serves as a base
        add_op(imm_op(cmd_mov, 4'd0, 4'd1, 8'h5a), "mov_imm");
        add_store(store_op(4'd0, 4'd1, 12'h010), "mov_imm_str", 32'h10, 32'h5a);
        add_op(imm_op(cmd_add, 4'd0, 4'd2, 8'd10), "add_imm");
        add_op(imm_op(cmd_add, 4'd2, 4'd3, 8'd5), "add_fwd_mem");
        add_op(imm_op(cmd_sub, 4'd3, 4'd4, 8'd3), "sub_fwd_mem");
        add_op(imm_op(cmd_sub, 4'd3, 4'd5, 8'd1), "sub_fwd_wb");
        // three slots behind the producer, read through the register file
        add_store(store_op(4'd0, 4'd3, 12'h020), "reg_write_through", 32'h20, 32'd15);
        add_store(store_op(4'd0, 4'd4, 12'h024), "sub_fwd_mem_str", 32'h24, 32'd12);
        add_store(store_op(4'd0, 4'd5, 12'h028), "sub_fwd_wb_str", 32'h28, 32'd14);
        add_op(imm_op(cmd_mov, 4'd0, 4'd6, 8'hf0), "mov_const_a");
        add_op(imm_op(cmd_mov, 4'd0, 4'd7, 8'h3c), "mov_const_b");
        add_op(reg_op(cmd_and, 4'd6, 4'd8, 4'd7), "and_reg");
        add_op(reg_op(cmd_orr, 4'd6, 4'd10, 4'd7), "orr_reg");
        add_store(store_op(4'd0, 4'd8, 12'h030), "and_reg_str", 32'h30, 32'h30);
        add_store(store_op(4'd0, 4'd10, 12'h034), "orr_reg_str", 32'h34, 32'hfc);
        add_op(reg_op(cmd_sub, 4'd10, 4'd11, 4'd8), "sub_reg");
        add_store(store_op(4'd0, 4'd11, 12'h038), "str_data_fwd", 32'h38, 32'hcc);
        add_op(imm_op(cmd_mov, 4'd0, 4'd9, rand_imm), "mov_random");
        add_store(store_op(4'd9, 4'd9, 12'h100), "random_base_str",
                  {24'b0, rand_imm} + 32'h100, {24'b0, rand_imm});
        add_op(imm_op(cmd_add, 4'd0, 4'd12, 8'h80), "add_base");
        add_store(store_op(4'd12, 4'd2, 12'h008), "str_base_fwd", 32'h88, 32'd10);
        add_op(reg_op(cmd_mov, 4'd0, 4'd13, 4'd12), "mov_reg");
        add_store(store_op(4'd0, 4'd13, 12'h03c), "mov_reg_str", 32'h3c, 32'h80);

        timeout_limit = n_rows + 20;

        // rows past the program stay zero bubbles
        foreach (imem[i]) begin
            imem[i] = '0;
        end
        for (int i = 0; i < n_rows; i++) begin
            imem[i] = row_word[i];
        end

        @(negedge reset);
        // the last row reaches memory three cycles after its fetch,
        // the bubbles after it leave room for a stray store to show
        while (pc != reset_pc + word_t'(4 * (n_rows + 6))) begin
            @(negedge clk);
        end
        @(posedge clk);
        check_equal("store count", store_rows.size(), stores_seen);

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
rtl/arm_pkg.sv
rtl/fetch_stage.sv
rtl/decode_unit.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/execute_stage.sv
rtl/core_top.sv
test/tb_clock.sv
test/core_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = core_tb
FILELIST = list.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
